/* verilog/psram_pkg.sv */
// --------------------
// psram package
// opcodes, widths and transfer counts for the quad-SPI PSRAM controller
// --------------------
`default_nettype none

package psram_pkg;

  // widths fixed by the device
  typedef logic [23:0] psram_addr_t;   // byte address, 64 Mbit part
  typedef logic [15:0] psram_data_t;   // host word
  typedef logic [3:0]  psram_nibble_t; // one quad bus beat
  typedef logic [7:0]  psram_cmd_t;

  // serial mode commands, sent on sio[0] during power-up
  localparam psram_cmd_t CMD_RSTEN  = 8'h66;
  localparam psram_cmd_t CMD_RST    = 8'h99;
  localparam psram_cmd_t CMD_QPI    = 8'h35;  // enter quad mode

  // quad mode commands
  localparam psram_cmd_t CMD_QREAD  = 8'hEB;
  localparam psram_cmd_t CMD_QWRITE = 8'h38;

  // transfer shape, in clock cycles (one nibble per cycle)
  localparam int CMD_NIBBLES      = 2;
  localparam int ADDR_NIBBLES     = 6;
  localparam int READ_WAIT_CYCLES = 6;
  localparam int DATA_NIBBLES     = 4;
  localparam int CE_GUARD_CYCLES  = 2;  // ce_n high time before ready returns (tCPH)

  // chip enable low time of a whole transfer
  localparam int XFER_WRITE_CYCLES = CMD_NIBBLES + ADDR_NIBBLES + DATA_NIBBLES;
  localparam int XFER_READ_CYCLES  = CMD_NIBBLES + ADDR_NIBBLES + READ_WAIT_CYCLES
                                     + DATA_NIBBLES;

  // power-up sequence
  typedef enum logic [2:0] {
    ST_DELAY,   // waiting for the power-up delay
    ST_RSTEN,
    ST_RST,
    ST_QPI,
    ST_DONE     // last command draining, then ready
  } init_state_t;

endpackage

`default_nettype wire

/* verilog/psram_powerup_timer.sv */
// --------------------
// power-up timer
// counts out the device power-up delay, paused by init_hold
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_powerup_timer (
  input  wire        clk,
  input  wire        rst_n,
  input  wire        init_hold,
  input  wire  [7:0] delay_units,  // delay in units of 256 cycles
  output logic       delay_done
);

  logic [15:0] count;
  logic        done_q;

  // match on the upper byte only, so one unit is 256 clocks
  logic hit;
  assign hit = (count[15:8] == delay_units);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      count  <= '0;
      done_q <= 1'b0;
    end else if (!done_q) begin
      if (hit) begin
        done_q <= 1'b1;           // sticky, counter freezes here
      end else if (!init_hold) begin
        count <= count + 16'd1;
      end
    end
  end

  assign delay_done = done_q;

endmodule

`default_nettype wire

/* verilog/psram_init_fsm.sv */
// --------------------
// init FSM
// sends RSTEN, RST and QPI after the power-up delay, then flags init_done
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_init_fsm (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire                    delay_done,
  input  wire                    cmd_ready,
  output psram_pkg::psram_cmd_t  cmd,
  output logic                   cmd_strobe,
  output logic                   init_done
);

  import psram_pkg::*;

  init_state_t state;

  // the sender only sees the strobe one cycle later, so cmd_ready is
  // still high in the cycle right after a strobe
  logic issue;
  assign issue = cmd_ready && !cmd_strobe;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= ST_DELAY;
      cmd_strobe <= 1'b0;
      init_done  <= 1'b0;
    end else begin
      cmd_strobe <= 1'b0;  // one-cycle pulse
      case (state)
        ST_DELAY: begin
          if (delay_done) state <= ST_RSTEN;
        end
        ST_RSTEN: begin
          if (issue) begin
            cmd_strobe <= 1'b1;
            state      <= ST_RST;
          end
        end
        ST_RST: begin
          if (issue) begin
            cmd_strobe <= 1'b1;
            state      <= ST_QPI;
          end
        end
        ST_QPI: begin
          if (issue) begin
            cmd_strobe <= 1'b1;
            state      <= ST_DONE;
          end
        end
        ST_DONE: begin
          if (issue) init_done <= 1'b1;  // QPI command has left the shifter
        end
        default: state <= ST_DELAY;
      endcase
    end
  end

  // opcode for the strobe issued this cycle
  always_ff @(posedge clk) begin
    if (issue) begin
      case (state)
        ST_RSTEN: cmd <= CMD_RSTEN;
        ST_RST:   cmd <= CMD_RST;
        ST_QPI:   cmd <= CMD_QPI;
        default:  cmd <= cmd;
      endcase
    end
  end

endmodule

`default_nettype wire

/* verilog/psram_spi_cmd.sv */
// --------------------
// serial command sender
// shifts one opcode out on sio[0], MSB first, with its own chip enable
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_spi_cmd (
  input  wire                    clk,
  input  wire                    rst_n,
  input  wire psram_pkg::psram_cmd_t cmd,
  input  wire                    cmd_strobe,
  output logic                   cmd_ready,
  output logic                   cmd_line,
  output logic                   cmd_ce_n
);

  import psram_pkg::*;

  psram_cmd_t shifter;
  logic       sending;
  logic [2:0] bit_cnt;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sending <= 1'b0;
      bit_cnt <= '0;
    end else if (!sending) begin
      if (cmd_strobe) begin
        sending <= 1'b1;
        bit_cnt <= '0;
      end
    end else begin
      bit_cnt <= bit_cnt + 3'd1;
      if (bit_cnt == 3'd7) sending <= 1'b0;  // eighth bit done
    end
  end

  // opcode payload
  always_ff @(posedge clk) begin
    if (!sending && cmd_strobe) begin
      shifter <= cmd;
    end else if (sending) begin
      shifter <= shifter << 1;
    end
  end

  assign cmd_line  = shifter[7];
  assign cmd_ce_n  = ~sending;
  assign cmd_ready = cmd_ce_n;  // idle exactly when deselected

endmodule

`default_nettype wire

/* verilog/psram_qpi_engine.sv */
// --------------------
// quad transfer engine
// one 16-bit read or write per strobe, with bus direction and ce_n guard
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_qpi_engine (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        enable,
  input  wire                        read_strobe,
  input  wire                        write_strobe,
  input  wire psram_pkg::psram_addr_t  addr,
  input  wire psram_pkg::psram_data_t  data_in,
  output psram_pkg::psram_data_t     data_out,
  output logic                       engine_ready,
  input  wire psram_pkg::psram_nibble_t sio_in,
  output psram_pkg::psram_nibble_t   sio_out,
  output logic                       sio_oe,
  output logic                       qpi_ce_n
);

  import psram_pkg::*;

  logic       busy;
  logic       reading;
  logic [4:0] phase;  // cycles since the transfer started
  // opcode, address and write data, MSB first
  logic [$bits(psram_cmd_t)+$bits(psram_addr_t)+$bits(psram_data_t)-1:0] tx_shift;

  logic accept;
  assign accept = enable && !busy && (read_strobe || write_strobe);

  // phase landmarks for the current direction
  logic [4:0] xfer_end;
  logic [4:0] guard_end;

  assign xfer_end  = reading ? 5'(XFER_READ_CYCLES) : 5'(XFER_WRITE_CYCLES);
  assign guard_end = xfer_end + 5'(CE_GUARD_CYCLES);

  // control
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy     <= 1'b0;
      reading  <= 1'b0;
      phase    <= '0;
      qpi_ce_n <= 1'b1;
      sio_oe   <= 1'b0;
    end else if (!busy) begin
      if (accept) begin
        busy    <= 1'b1;
        reading <= read_strobe;  // read wins over write
        phase   <= '0;
      end
    end else begin
      phase <= phase + 5'd1;
      if (phase == 5'd0) begin
        qpi_ce_n <= 1'b0;
        sio_oe   <= 1'b1;
      end
      // turn the bus around once the address is out
      if (reading && phase == 5'(CMD_NIBBLES + ADDR_NIBBLES)) sio_oe <= 1'b0;
      if (phase == xfer_end) begin
        qpi_ce_n <= 1'b1;
        sio_oe   <= 1'b0;
      end
      if (phase == guard_end) busy <= 1'b0;  // tCPH met
    end
  end

  // a read turns the bus around before the tail of the shifter goes out
  always_ff @(posedge clk) begin
    if (accept) begin
      tx_shift <= {(read_strobe ? CMD_QREAD : CMD_QWRITE), addr, data_in};
    end else if (busy) begin
      sio_out  <= tx_shift[$bits(tx_shift)-1 -: 4];
      tx_shift <= tx_shift << 4;
    end
  end

  // read data, one nibble per cycle once the wait cycles are over
  always_ff @(posedge clk) begin
    if (busy && reading && phase > 5'(CMD_NIBBLES + ADDR_NIBBLES + READ_WAIT_CYCLES)
        && phase <= xfer_end) begin
      data_out <= {data_out[11:0], sio_in};
    end
  end

  assign engine_ready = ~busy;

endmodule

`default_nettype wire

/* verilog/psram_ctrl.sv */
// --------------------
// quad-SPI PSRAM controller
// power-up sequence, serial init commands and quad read/write, one shared bus
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_ctrl (
  input  wire                        clk,
  input  wire                        rst_n,
  input  wire                        init_hold,
  input  wire                  [7:0] delay_units,
  input  wire                        read_strobe,
  input  wire                        write_strobe,
  input  wire psram_pkg::psram_addr_t  addr,
  input  wire psram_pkg::psram_data_t  data_in,
  output psram_pkg::psram_data_t     data_out,
  output logic                       ready,
  inout  wire                  [3:0] mem_sio,
  output logic                       mem_ce_n,
  output logic                       mem_clk
);

  import psram_pkg::*;

  logic          delay_done;
  psram_cmd_t    cmd;
  logic          cmd_strobe;
  logic          cmd_ready;
  logic          cmd_line;
  logic          cmd_ce_n;
  logic          init_done;
  logic          engine_ready;
  psram_nibble_t sio_out;
  logic          sio_oe;
  logic          qpi_ce_n;

  psram_powerup_timer u_timer (
    .clk         (clk),
    .rst_n       (rst_n),
    .init_hold   (init_hold),
    .delay_units (delay_units),
    .delay_done  (delay_done)
  );

  psram_init_fsm u_init (
    .clk        (clk),
    .rst_n      (rst_n),
    .delay_done (delay_done),
    .cmd_ready  (cmd_ready),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .init_done  (init_done)
  );

  psram_spi_cmd u_spi_cmd (
    .clk        (clk),
    .rst_n      (rst_n),
    .cmd        (cmd),
    .cmd_strobe (cmd_strobe),
    .cmd_ready  (cmd_ready),
    .cmd_line   (cmd_line),
    .cmd_ce_n   (cmd_ce_n)
  );

  psram_qpi_engine u_engine (
    .clk          (clk),
    .rst_n        (rst_n),
    .enable       (init_done),  // no host traffic before the device is in quad mode
    .read_strobe  (read_strobe),
    .write_strobe (write_strobe),
    .addr         (addr),
    .data_in      (data_in),
    .data_out     (data_out),
    .engine_ready (engine_ready),
    .sio_in       (mem_sio),
    .sio_out      (sio_out),
    .sio_oe       (sio_oe),
    .qpi_ce_n     (qpi_ce_n)
  );

  // serial commands own sio[0] while their ce_n is low
  assign mem_sio = !cmd_ce_n ? {3'bzzz, cmd_line} :
                   sio_oe    ? sio_out             : 4'bzzzz;

  assign mem_ce_n = cmd_ce_n & qpi_ce_n;
  assign mem_clk  = ~clk;  // device samples on falling clk
  assign ready    = init_done & engine_ready;

endmodule

`default_nettype wire

/* dv/psram_qpi_model.sv */
// --------------------
// quad-SPI PSRAM device model
// serial init commands, then quad reads and writes into a sparse array
// --------------------
`timescale 1ns/100ps
`default_nettype none

module psram_qpi_model (
  input  wire         mem_clk,
  input  wire         mem_ce_n,
  inout  wire   [3:0] mem_sio,
  output logic        quad_mode,
  output logic  [1:0] init_count,   // serial commands accepted so far
  output logic [31:0] xfer_count,   // completed quad transfers
  output logic        proto_err
);

  import psram_pkg::*;

  logic [15:0] store [logic [23:0]];  // unwritten words read as zero

  logic        active;
  int          edge_cnt;
  logic  [7:0] serial_shift;
  logic  [7:0] op;
  logic [23:0] addr;
  logic [15:0] wdata;
  logic [15:0] rdata;
  logic  [7:0] init_expected;
  logic        drive_en;
  logic  [3:0] drive_val;

  assign mem_sio = drive_en ? drive_val : 4'bzzzz;

  task automatic flag_error(input string msg);
    $display("model: %s", msg);
    proto_err = 1'b1;
  endtask

  initial begin
    quad_mode  = 1'b0;
    init_count = 2'd0;
    xfer_count = 32'd0;
    proto_err  = 1'b0;
    active     = 1'b0;
    edge_cnt   = 0;
    drive_en   = 1'b0;
    drive_val  = 4'h0;
  end

  // the device samples and drives on its own rising clock, the falling clk
  always @(posedge mem_clk) begin
    if (!mem_ce_n) begin
      active   = 1'b1;
      edge_cnt = edge_cnt + 1;
      if (!quad_mode) begin
        serial_shift = {serial_shift[6:0], mem_sio[0]};  // MSB first on sio[0]
      end else if (edge_cnt <= 2) begin
        op = {op[3:0], mem_sio};
      end else if (edge_cnt <= 8) begin
        addr = {addr[19:0], mem_sio};
      end else if (op == CMD_QWRITE && edge_cnt <= 12) begin
        wdata = {wdata[11:0], mem_sio};
      end else if (op == CMD_QREAD && edge_cnt >= 15 && edge_cnt <= 18) begin
        // six wait cycles are over, put the word out high nibble first
        if (edge_cnt == 15) rdata = store.exists(addr) ? store[addr] : 16'h0000;
        drive_val = rdata[15:12];
        drive_en  = 1'b1;
        rdata     = rdata << 4;
      end
    end else if (active) begin
      // chip enable went high, close the transfer
      active   = 1'b0;
      drive_en = 1'b0;
      if (!quad_mode) begin
        case (init_count)
          2'd0:    init_expected = CMD_RSTEN;
          2'd1:    init_expected = CMD_RST;
          default: init_expected = CMD_QPI;
        endcase
        if (edge_cnt != 8) begin
          flag_error($sformatf("serial command with %0d clocks instead of 8", edge_cnt));
        end else if (serial_shift != init_expected) begin
          flag_error($sformatf("serial command 0x%02h out of order, expected 0x%02h",
                               serial_shift, init_expected));
        end else begin
          init_count = init_count + 2'd1;
          if (init_count == 2'd3) begin
            quad_mode = 1'b1;
            $display("model: quad mode entered at %0t", $time);
          end
        end
      end else if (op == CMD_QWRITE) begin
        if (edge_cnt != 12) begin
          flag_error($sformatf("quad write with %0d clocks instead of 12", edge_cnt));
        end else begin
          store[addr] = wdata;
          xfer_count  = xfer_count + 32'd1;
        end
      end else if (op == CMD_QREAD) begin
        if (edge_cnt != 18) begin
          flag_error($sformatf("quad read with %0d clocks instead of 18", edge_cnt));
        end else begin
          xfer_count = xfer_count + 32'd1;
        end
      end else begin
        flag_error($sformatf("unknown quad command 0x%02h", op));
      end
      edge_cnt = 0;
    end
  end

endmodule

`default_nettype wire

/* dv/tb_psram_ctrl.sv */
// --------------------
// PSRAM controller testbench
// power-up, table of host reads and writes, device model on the bus
// --------------------
`timescale 1ns/100ps
`default_nettype none

module tb_psram_ctrl;

  import psram_pkg::*;

  localparam int DELAY_UNITS     = 2;
  localparam int HOLD_CYCLES     = DELAY_UNITS * 256 + 100;  // outlasts the whole init sequence
  localparam int RAND_WRITES     = 8;
  localparam int RAND_OVERWRITES = 4;
  localparam int TABLE_LEN       = 9 + RAND_WRITES + RAND_OVERWRITES + RAND_WRITES;
  localparam int TIMEOUT_CYCLES  = (DELAY_UNITS * 256 + 100 + TABLE_LEN * 30) * 2;

  localparam logic [1:0] OP_WRITE = 2'd0;
  localparam logic [1:0] OP_READ  = 2'd1;
  localparam logic [1:0] OP_STRAY = 2'd2;  // write, then strobes while busy

  logic        clk;
  logic        rst_n;
  logic        init_hold;
  logic  [7:0] delay_units;
  logic        read_strobe;
  logic        write_strobe;
  psram_addr_t addr;
  psram_data_t data_in;
  psram_data_t data_out;
  logic        ready;
  wire   [3:0] mem_sio;
  wire         mem_ce_n;
  wire         mem_clk;

  logic        quad_mode;
  logic  [1:0] init_count;
  logic [31:0] xfer_count;
  logic        proto_err;

  // stimulus table
  logic  [1:0] tbl_op   [TABLE_LEN];
  psram_addr_t tbl_addr [TABLE_LEN];
  psram_data_t tbl_data [TABLE_LEN];
  psram_data_t tbl_exp  [TABLE_LEN];
  int          tbl_n;

  psram_data_t shadow [psram_addr_t];  // last value written per address
  int          honored;                // strobes that must reach the device
  int          cycle_count;
  int          wait_cycles;

  psram_ctrl UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .init_hold    (init_hold),
    .delay_units  (delay_units),
    .read_strobe  (read_strobe),
    .write_strobe (write_strobe),
    .addr         (addr),
    .data_in      (data_in),
    .data_out     (data_out),
    .ready        (ready),
    .mem_sio      (mem_sio),
    .mem_ce_n     (mem_ce_n),
    .mem_clk      (mem_clk)
  );

  psram_qpi_model u_model (
    .mem_clk    (mem_clk),
    .mem_ce_n   (mem_ce_n),
    .mem_sio    (mem_sio),
    .quad_mode  (quad_mode),
    .init_count (init_count),
    .xfer_count (xfer_count),
    .proto_err  (proto_err)
  );

  always #10 clk = ~clk;

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
    if (got !== expected) begin
      $display("ERROR at %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, expected);
      $display("TEST FAIL");
      $fatal(1, "check of %s failed", name);
    end
  endtask

  task automatic add_entry(input logic [1:0] op, input psram_addr_t a,
                           input psram_data_t d, input psram_data_t exp);
    tbl_op[tbl_n]   = op;
    tbl_addr[tbl_n] = a;
    tbl_data[tbl_n] = d;
    tbl_exp[tbl_n]  = exp;
    if (op != OP_READ) shadow[a] = d;
    tbl_n = tbl_n + 1;
  endtask

  task automatic build_table();
    logic [31:0] rnd;
    psram_addr_t rnd_addr [RAND_WRITES];
    psram_addr_t a;
    add_entry(OP_WRITE, 24'h000010, 16'h1234, 16'h1234);
    add_entry(OP_WRITE, 24'h000020, 16'hABCD, 16'hABCD);
    add_entry(OP_WRITE, 24'h7FFFFE, 16'hBEEF, 16'hBEEF);  // top word of the part
    add_entry(OP_READ,  24'h000010, 16'h0000, 16'h1234);
    add_entry(OP_READ,  24'h000020, 16'h0000, 16'hABCD);
    add_entry(OP_READ,  24'h7FFFFE, 16'h0000, 16'hBEEF);
    add_entry(OP_READ,  24'h000040, 16'h0000, 16'h0000);  // never written
    add_entry(OP_STRAY, 24'h000020, 16'h5A5A, 16'h5A5A);
    add_entry(OP_READ,  24'h000020, 16'h0000, 16'h5A5A);
    for (int k = 0; k < RAND_WRITES; k++) begin
      rnd         = $urandom;
      rnd_addr[k] = rnd[23:0] & 24'h7FFFFE;
      rnd         = $urandom;
      add_entry(OP_WRITE, rnd_addr[k], rnd[15:0], rnd[15:0]);
    end
    for (int k = 0; k < RAND_OVERWRITES; k++) begin
      rnd = $urandom;
      a   = rnd_addr[rnd[2:0]];
      rnd = $urandom;
      add_entry(OP_WRITE, a, rnd[15:0], rnd[15:0]);
    end
    for (int k = 0; k < RAND_WRITES; k++) begin
      add_entry(OP_READ, rnd_addr[k], 16'h0000, shadow[rnd_addr[k]]);
    end
  endtask

  task automatic wait_ready();
    while (ready !== 1'b1) @(negedge clk);
  endtask

  task automatic run_entry(input int idx);
    addr    = tbl_addr[idx];
    data_in = tbl_data[idx];
    if (tbl_op[idx] == OP_READ) read_strobe = 1'b1;
    else write_strobe = 1'b1;
    @(negedge clk);
    read_strobe  = 1'b0;
    write_strobe = 1'b0;
    honored      = honored + 1;
    check_value("ready", 32'(ready), 32'd0);  // falls the cycle after the strobe
    if (tbl_op[idx] == OP_STRAY) begin
      data_in      = ~tbl_data[idx];
      write_strobe = 1'b1;
      @(negedge clk);
      write_strobe = 1'b0;
      check_value("ready", 32'(ready), 32'd0);
      read_strobe  = 1'b1;
      @(negedge clk);
      read_strobe  = 1'b0;
    end
    wait_ready();
    if (tbl_op[idx] == OP_READ) begin
      check_value("data_out", 32'(data_out), 32'(tbl_exp[idx]));
    end
    check_value("xfer_count", xfer_count, 32'(honored));
  endtask

  // ready may only be seen once the device is in quad mode
  always @(negedge clk) begin
    if (ready === 1'b1 && quad_mode !== 1'b1) begin
      check_value("quad_mode", 32'(quad_mode), 32'd1);
    end
  end

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (proto_err === 1'b1) begin
      $display("TEST FAIL");
      $fatal(1, "device model reported a protocol error");
    end else if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("TEST FAIL");
      $fatal(1, "timeout after %0d cycles, the controller stopped responding", cycle_count);
    end
  end

  initial begin
    clk          = 1'b0;
    rst_n        = 1'b0;
    init_hold    = 1'b1;
    delay_units  = 8'(DELAY_UNITS);
    read_strobe  = 1'b0;
    write_strobe = 1'b0;
    addr         = '0;
    data_in      = '0;
    tbl_n        = 0;
    honored      = 0;
    cycle_count  = 0;
    wait_cycles  = 0;
    void'($urandom(35));
    build_table();

    repeat (5) @(negedge clk);
    rst_n = 1'b1;
    check_value("ready", 32'(ready), 32'd0);
    check_value("mem_ce_n", 32'(mem_ce_n), 32'd1);

    // timer is paused so no init command may go out on the bus
    repeat (HOLD_CYCLES) @(negedge clk);
    check_value("ready", 32'(ready), 32'd0);
    check_value("init_count", 32'(init_count), 32'd0);
    init_hold = 1'b0;

    while (ready !== 1'b1) begin
      @(negedge clk);
      wait_cycles = wait_cycles + 1;
    end
    $display("init done at %0t, fsm in %s", $time, UUT.u_init.state.name());
    check_value("init_wait_ok", 32'(wait_cycles >= DELAY_UNITS * 256), 32'd1);
    check_value("init_count", 32'(init_count), 32'd3);
    check_value("quad_mode", 32'(quad_mode), 32'd1);

    for (int i = 0; i < TABLE_LEN; i++) begin
      run_entry(i);
    end

    $display("TEST PASS");
    $finish;
  end

endmodule

`default_nettype wire

/* list.f */
verilog/psram_pkg.sv
verilog/psram_powerup_timer.sv
verilog/psram_init_fsm.sv
verilog/psram_spi_cmd.sv
verilog/psram_qpi_engine.sv
verilog/psram_ctrl.sv
dv/psram_qpi_model.sv
dv/tb_psram_ctrl.sv

/* run.sh */
#!/bin/sh
# build and run the PSRAM controller testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --top-module tb_psram_ctrl -f list.f -o sim_psram \
  > build.log 2>&1 || { cat build.log; echo "verilator build failed"; exit 1; }

./obj_dir/sim_psram > sim.log 2>&1
cat sim.log

grep -q "^TEST PASS$" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }
